/* common/boot_rom_config.svh */
`ifndef BOOT_ROM_CONFIG_SVH
`define BOOT_ROM_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot image geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BOOT_IMAGE_WORDS 64 // number of 16-bit words copied out of flash.

`define BOOT_BANK_AW 5 // word address bits inside one RAM bank.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flash layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// The image starts one megabyte into the flash, past the FPGA bitstream.
`define BOOT_FLASH_BASE 24'h100000 // byte offset of word zero.

`endif

/* common/boot_rom_pkg.sv */
`include "boot_rom_config.svh"

package boot_rom_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data and address types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [15:0] word_t; // one instruction or data word.
  typedef logic [`BOOT_BANK_AW:0] ram_addr_t; // the top bit picks the bank.
  typedef logic [23:0] flash_addr_t; // flash byte address.

  // Request from any peer towards the arbiter.
  typedef struct packed {
    logic      valid;
    logic      write;
    ram_addr_t addr;
    word_t     wdata;
  } ram_req_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machines
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    spi_idle, spi_command, spi_addr_hi, spi_addr_mid,
    spi_addr_lo, spi_data_hi, spi_data_lo, spi_done
  } spi_state_e;

  typedef enum logic [1:0] {load_request, load_wait, load_finished} load_state_e;

  typedef enum logic {apb_idle, apb_access} apb_state_e;

endpackage

/* flash/spi_flash_reader.sv */
module spi_flash_reader (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rd_start,
  input  boot_rom_pkg::flash_addr_t rd_addr,
  output logic                      rd_done,
  output boot_rom_pkg::word_t       rd_data,
  output logic                      spi_cs,
  output logic                      spi_sclk,
  output logic                      spi_mosi,
  input  logic                      spi_miso
);

  boot_rom_pkg::spi_state_e state;
  logic [7:0] buffer; // shifts out on mosi and in from miso at the same time.
  logic [3:0] bit_cnt; // bits left in the current byte.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus control and sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= boot_rom_pkg::spi_idle;
      bit_cnt  <= 4'd0;
      rd_done  <= 1'b0;
      spi_cs   <= 1'b1;
      spi_sclk <= 1'b1; // mode 3 idles high.
      spi_mosi <= 1'b1;
    end else begin
      rd_done <= 1'b0;
      if (bit_cnt != 4'd0) begin
        if (spi_sclk) begin
          spi_sclk <= 1'b0; // falling edge launches the next bit.
          spi_mosi <= buffer[7];
        end else begin
          spi_sclk <= 1'b1; // rising edge, the datapath samples miso.
          bit_cnt  <= bit_cnt - 4'd1;
        end
      end else begin
        case (state)
          boot_rom_pkg::spi_idle: begin
            if (rd_start) begin
              spi_cs  <= 1'b0;
              bit_cnt <= 4'd8;
              state   <= boot_rom_pkg::spi_command;
            end
          end
          boot_rom_pkg::spi_command: begin
            bit_cnt <= 4'd8;
            state   <= boot_rom_pkg::spi_addr_hi;
          end
          boot_rom_pkg::spi_addr_hi: begin
            bit_cnt <= 4'd8;
            state   <= boot_rom_pkg::spi_addr_mid;
          end
          boot_rom_pkg::spi_addr_mid: begin
            bit_cnt <= 4'd8;
            state   <= boot_rom_pkg::spi_addr_lo;
          end
          boot_rom_pkg::spi_addr_lo: begin
            bit_cnt <= 4'd8; // first data byte follows the address directly.
            state   <= boot_rom_pkg::spi_data_hi;
          end
          boot_rom_pkg::spi_data_hi: begin
            bit_cnt <= 4'd8;
            state   <= boot_rom_pkg::spi_data_lo;
          end
          boot_rom_pkg::spi_data_lo: begin
            rd_done <= 1'b1;
            state   <= boot_rom_pkg::spi_done;
          end
          default: begin
            spi_cs <= 1'b1; // start requests are ignored in this cycle.
            state  <= boot_rom_pkg::spi_idle;
          end
        endcase
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shift buffer and word assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (bit_cnt != 4'd0) begin
      if (!spi_sclk) begin
        buffer <= {buffer[6:0], spi_miso};
      end
    end else begin
      case (state)
        boot_rom_pkg::spi_idle:     buffer <= 8'h03; // READ command.
        boot_rom_pkg::spi_command:  buffer <= rd_addr[23:16];
        boot_rom_pkg::spi_addr_hi:  buffer <= rd_addr[15:8];
        boot_rom_pkg::spi_addr_mid: buffer <= rd_addr[7:0];
        boot_rom_pkg::spi_data_hi:  rd_data[15:8] <= buffer; // big-endian, high byte first.
        boot_rom_pkg::spi_data_lo:  rd_data[7:0] <= buffer;
        default: ;
      endcase
    end
  end

endmodule

/* flash/image_loader.sv */
`include "boot_rom_config.svh"

module image_loader (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic                      rd_start,
  output boot_rom_pkg::flash_addr_t rd_addr,
  input  logic                      rd_done,
  input  boot_rom_pkg::word_t       rd_data,
  output boot_rom_pkg::ram_req_t    load_req,
  output logic                      ready
);

  localparam boot_rom_pkg::ram_addr_t LAST_INDEX =
    boot_rom_pkg::ram_addr_t'(`BOOT_IMAGE_WORDS - 1);

  boot_rom_pkg::load_state_e state;
  boot_rom_pkg::ram_addr_t   index; // word being fetched from flash.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= boot_rom_pkg::load_request;
      index <= '0;
    end else begin
      case (state)
        boot_rom_pkg::load_request: state <= boot_rom_pkg::load_wait;
        boot_rom_pkg::load_wait: begin
          if (rd_done) begin
            if (index == LAST_INDEX) begin
              state <= boot_rom_pkg::load_finished;
            end else begin
              index <= index + 1'b1;
              state <= boot_rom_pkg::load_request;
            end
          end
        end
        default: state <= boot_rom_pkg::load_finished; // stays here until reset.
      endcase
    end
  end

  assign rd_start = (state != boot_rom_pkg::load_finished);
  // each word occupies two flash bytes.
  assign rd_addr  = boot_rom_pkg::flash_addr_t'(`BOOT_FLASH_BASE)
                  + boot_rom_pkg::flash_addr_t'({index, 1'b0});
  assign ready    = (state == boot_rom_pkg::load_finished);

  always_comb begin
    load_req.valid = rd_done && (state == boot_rom_pkg::load_wait);
    load_req.write = 1'b1;
    load_req.addr  = index;
    load_req.wdata = rd_data;
  end

endmodule

/* verilog/shadow_ram.sv */
`include "boot_rom_config.svh"

module shadow_ram (
  input  logic                   clk,
  input  boot_rom_pkg::ram_req_t req,
  output boot_rom_pkg::word_t    rdata
);

  localparam int DEPTH = 1 << `BOOT_BANK_AW;

  boot_rom_pkg::word_t bank_lo [DEPTH];
  boot_rom_pkg::word_t bank_hi [DEPTH];
  boot_rom_pkg::word_t dout_lo;
  boot_rom_pkg::word_t dout_hi;
  logic [`BOOT_BANK_AW-1:0] word_addr;
  logic bank_sel;
  logic bank_sel_q; // bank of the read issued last cycle.

  assign word_addr = req.addr[`BOOT_BANK_AW-1:0];
  assign bank_sel  = req.addr[`BOOT_BANK_AW];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bank arrays
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (req.valid) begin
      if (req.write && !bank_sel) begin
        bank_lo[word_addr] <= req.wdata;
      end
      if (req.write && bank_sel) begin
        bank_hi[word_addr] <= req.wdata;
      end
      dout_lo    <= bank_lo[word_addr]; // both banks read, the select picks one.
      dout_hi    <= bank_hi[word_addr];
      bank_sel_q <= bank_sel;
    end
  end

  // The select has to line up with the one-cycle array latency.
  assign rdata = bank_sel_q ? dout_hi : dout_lo;

endmodule

/* verilog/ram_arbiter.sv */
module ram_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ready,
  input  boot_rom_pkg::ram_req_t load_req,
  input  boot_rom_pkg::ram_req_t fetch_req,
  input  boot_rom_pkg::ram_req_t apb_req,
  output logic                   load_gnt,
  output logic                   fetch_gnt,
  output logic                   apb_gnt,
  output boot_rom_pkg::ram_req_t mem_req,
  input  boot_rom_pkg::word_t    rdata,
  output boot_rom_pkg::word_t    fetch_data
);

  logic fetch_won_q; // fetch owned the RAM in the previous cycle.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed priority: loader, fetch, APB
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Only the loader may touch the RAM before the image is complete.
  assign load_gnt  = load_req.valid;
  assign fetch_gnt = ready && fetch_req.valid && !load_req.valid;
  assign apb_gnt   = ready && apb_req.valid && !fetch_req.valid && !load_req.valid;

  always_comb begin
    if (load_gnt) begin
      mem_req = load_req;
    end else if (fetch_gnt) begin
      mem_req = fetch_req;
    end else if (apb_gnt) begin
      mem_req = apb_req;
    end else begin
      mem_req = '0; // idle cycle, nothing reaches the RAM.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch return path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_won_q <= 1'b0;
    end else begin
      fetch_won_q <= fetch_gnt;
    end
  end

  assign fetch_data = fetch_won_q ? rdata : '0; // zero while loading too.

endmodule

/* verilog/apb_ram_port.sv */
module apb_ram_port (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  boot_rom_pkg::ram_addr_t paddr,
  input  boot_rom_pkg::word_t     pwdata,
  output boot_rom_pkg::word_t     prdata,
  output logic                    pready,
  output boot_rom_pkg::ram_req_t  apb_req,
  input  logic                    apb_gnt,
  input  boot_rom_pkg::word_t     rdata
);

  boot_rom_pkg::apb_state_e state;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // transfer tracking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= boot_rom_pkg::apb_idle;
      pready <= 1'b0;
    end else begin
      pready <= 1'b0;
      case (state)
        boot_rom_pkg::apb_idle: begin
          if (psel && !penable) begin
            state <= boot_rom_pkg::apb_access; // setup phase seen.
          end
        end
        default: begin
          if (apb_gnt) begin
            pready <= 1'b1; // RAM data arrives together with pready.
            state  <= boot_rom_pkg::apb_idle;
          end
        end
      endcase
    end
  end

  // The request stays up for as long as the arbiter holds it off.
  always_comb begin
    apb_req.valid = (state == boot_rom_pkg::apb_access) && psel && penable;
    apb_req.write = pwrite;
    apb_req.addr  = paddr;
    apb_req.wdata = pwdata;
  end

  assign prdata = rdata; // valid in the pready cycle.

endmodule

/* verilog/boot_rom_top.sv */
module boot_rom_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fetch_en,
  input  boot_rom_pkg::ram_addr_t fetch_addr,
  output boot_rom_pkg::word_t     instruction,
  output logic                    ready,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  boot_rom_pkg::ram_addr_t paddr,
  input  boot_rom_pkg::word_t     pwdata,
  output boot_rom_pkg::word_t     prdata,
  output logic                    pready,
  output logic                    spi_cs,
  output logic                    spi_sclk,
  output logic                    spi_mosi,
  input  logic                    spi_miso
);

  logic                      rd_start;
  logic                      rd_done;
  boot_rom_pkg::flash_addr_t rd_addr;
  boot_rom_pkg::word_t       rd_data;
  boot_rom_pkg::ram_req_t    load_req;
  boot_rom_pkg::ram_req_t    fetch_req;
  boot_rom_pkg::ram_req_t    apb_req;
  boot_rom_pkg::ram_req_t    mem_req;
  boot_rom_pkg::word_t       rdata;
  logic                      load_gnt; // the loader is never held off.
  logic                      fetch_gnt; // always granted once ready is high.
  logic                      apb_gnt;

  // fetches are plain reads.
  assign fetch_req = '{valid: fetch_en, write: 1'b0, addr: fetch_addr, wdata: '0};

  spi_flash_reader u_spi_flash_reader (
    .clk(clk), .rst_n(rst_n),
    .rd_start(rd_start), .rd_addr(rd_addr), .rd_done(rd_done), .rd_data(rd_data),
    .spi_cs(spi_cs), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  image_loader u_image_loader (
    .clk(clk), .rst_n(rst_n),
    .rd_start(rd_start), .rd_addr(rd_addr), .rd_done(rd_done), .rd_data(rd_data),
    .load_req(load_req), .ready(ready)
  );

  ram_arbiter u_ram_arbiter (
    .clk(clk), .rst_n(rst_n), .ready(ready),
    .load_req(load_req), .fetch_req(fetch_req), .apb_req(apb_req),
    .load_gnt(load_gnt), .fetch_gnt(fetch_gnt), .apb_gnt(apb_gnt),
    .mem_req(mem_req), .rdata(rdata), .fetch_data(instruction)
  );

  apb_ram_port u_apb_ram_port (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready),
    .apb_req(apb_req), .apb_gnt(apb_gnt), .rdata(rdata)
  );

  shadow_ram u_shadow_ram (
    .clk(clk), .req(mem_req), .rdata(rdata)
  );

endmodule

/* testbench/spi_flash_model.sv */
module spi_flash_model (
  input  logic spi_cs,
  input  logic spi_sclk,
  input  logic spi_mosi,
  output logic spi_miso
);

  logic [31:0] header; // command byte followed by the 24-bit address.
  int unsigned bit_count; // sclk rising edges seen since cs fell.
  logic [23:0] byte_addr;
  logic [7:0] data_byte;

  // each byte is a mix of the low and middle address bytes.
  function automatic logic [7:0] flash_byte(logic [23:0] addr);
    return addr[7:0] ^ 8'h5a ^ addr[15:8];
  endfunction

  initial spi_miso = 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // mode 3, sample on rising and launch on falling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge spi_sclk or posedge spi_cs) begin
    if (spi_cs) begin
      bit_count = 0; // a new transaction starts with the command.
    end else begin
      if (bit_count < 32) begin
        header = {header[30:0], spi_mosi};
      end
      bit_count = bit_count + 1;
    end
  end

  always @(negedge spi_sclk) begin
    if (!spi_cs && bit_count >= 32) begin
      byte_addr = header[23:0] + 24'((bit_count - 32) / 8); // sequential read.
      data_byte = flash_byte(byte_addr);
      spi_miso <= data_byte[7 - ((bit_count - 32) % 8)];
    end
  end

endmodule

/* testbench/boot_rom_sva.sv */
`include "boot_rom_config.svh"

module boot_rom_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                ready,
  input logic                spi_cs,
  input logic                spi_sclk,
  input logic                spi_mosi,
  input logic                pready,
  input boot_rom_pkg::word_t instruction
);

  int unsigned failures = 0; // watched by the testbench top.
  logic [31:0] mosi_bits;
  logic [5:0]  bit_count;
  int unsigned word_count; // finished flash transactions.
  logic        cs_q;

  function automatic logic [31:0] read_header(int unsigned index);
    return {8'h03, 24'(`BOOT_FLASH_BASE + 2 * index)};
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mosi_bits  <= '0;
      bit_count  <= '0;
      word_count <= 0;
      cs_q       <= 1'b1;
    end else begin
      cs_q <= spi_cs;
      if (spi_cs) begin
        bit_count <= '0;
      end else if (!spi_sclk) begin
        mosi_bits <= {mosi_bits[30:0], spi_mosi}; // mosi is steady while sclk is low.
        bit_count <= bit_count + 6'd1;
      end
      if (spi_cs && !cs_q) begin
        word_count <= word_count + 1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  reset_state: assert property (@(posedge clk) $rose(rst_n) |->
      (!ready && spi_cs && spi_sclk && !pready))
    else begin
      $error("Mismatch reset state: ready %h spi_cs %h spi_sclk %h pready %h",
             $sampled(ready), $sampled(spi_cs), $sampled(spi_sclk), $sampled(pready));
      failures++;
    end

  ready_holds: assert property (@(posedge clk) disable iff (!rst_n) ready |=> ready)
    else begin
      $error("ready fell after it had been raised");
      failures++;
    end

  read_command: assert property (@(posedge clk) disable iff (!rst_n)
      (!spi_cs && !spi_sclk && bit_count == 6'd31) |=>
      (mosi_bits == read_header(word_count)))
    else begin
      $error("Mismatch spi_mosi header: got %h, expected %h",
             $sampled(mosi_bits), read_header($sampled(word_count)));
      failures++;
    end

  no_extra_read: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(spi_cs) |-> (word_count < `BOOT_IMAGE_WORDS))
    else begin
      $error("a flash read started after the whole image was loaded");
      failures++;
    end

  fetch_zero: assert property (@(posedge clk) disable iff (!rst_n)
      !ready |-> (instruction == '0))
    else begin
      $error("Mismatch instruction before ready: got %h, expected 0000",
             $sampled(instruction));
      failures++;
    end

  apb_after_ready: assert property (@(posedge clk) disable iff (!rst_n) pready |-> ready)
    else begin
      $error("pready was raised while the image was still loading");
      failures++;
    end

endmodule

bind boot_rom_top boot_rom_sva u_boot_rom_sva (
  .clk(clk), .rst_n(rst_n), .ready(ready), .spi_cs(spi_cs), .spi_sclk(spi_sclk),
  .spi_mosi(spi_mosi), .pready(pready), .instruction(instruction)
);

/* testbench/boot_rom_tb.sv */
`include "boot_rom_config.svh"

module boot_rom_tb;

  localparam int          DRIVE_DELAY = 1;
  localparam int unsigned LOAD_TIMEOUT = 20000; // covers the whole image load.
  localparam int unsigned APB_TIMEOUT = 50;
  localparam int          HOLD_CYCLES = 16;
  localparam int          EARLY_FETCHES = 256; // spans the first two loader writes.

  logic clk, rst_n, fetch_en, psel, penable, pwrite, ready, pready;
  logic spi_cs, spi_sclk, spi_mosi, spi_miso;
  boot_rom_pkg::ram_addr_t fetch_addr, paddr, addr;
  boot_rom_pkg::word_t     pwdata, prdata, instruction, data, got;
  boot_rom_pkg::word_t     expected_mem [`BOOT_IMAGE_WORDS];
  logic [31:0]             lfsr_state = 32'h99c6787f;

  boot_rom_top u_boot_rom_top (
    .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .fetch_addr(fetch_addr),
    .instruction(instruction), .ready(ready), .psel(psel), .penable(penable),
    .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .spi_cs(spi_cs), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  spi_flash_model u_spi_flash_model (
    .spi_cs(spi_cs), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference data and random numbers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic boot_rom_pkg::word_t image_word(int unsigned index);
    logic [23:0] a;
    a = 24'(`BOOT_FLASH_BASE + 2 * index);
    return {a[7:0] ^ 8'h5a ^ a[15:8], (a[7:0] + 8'd1) ^ 8'h5a ^ a[15:8]}; // base is even.
  endfunction

  function automatic logic [15:0] take_bits(int unsigned n);
    logic [15:0] value;
    value = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      value = {value[14:0], lfsr_state[0]};
    end
    return value;
  endfunction

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic mismatch(string name, logic [15:0] seen, logic [15:0] want);
    fail_run($sformatf("Mismatch %s: got %h, expected %h", name, seen, want));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic fetch_and_check(boot_rom_pkg::ram_addr_t a);
    fetch_en   = 1'b1;
    fetch_addr = a;
    next_cycle();
    fetch_en = 1'b0;
    assert (instruction == expected_mem[a]) else mismatch("instruction", instruction,
                                                          expected_mem[a]);
  endtask

  task automatic wait_for_pready(int unsigned timeout);
    int unsigned cycles;
    cycles = 0;
    next_cycle();
    while (!pready && cycles < timeout) begin
      cycles++;
      next_cycle();
    end
    assert (pready) else fail_run("APB transfer got no pready before its timeout");
  endtask

  task automatic apb_transfer(logic write, boot_rom_pkg::ram_addr_t a,
                              boot_rom_pkg::word_t wdata, int unsigned timeout,
                              output boot_rom_pkg::word_t rdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = a;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;
    wait_for_pready(timeout);
    rdata   = prdata;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  always @(posedge clk) begin
    if (u_boot_rom_top.u_boot_rom_sva.failures != 0) begin
      fail_run("an assertion bound to boot_rom_top failed");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst_n      = 1'b0;
    fetch_en   = 1'b0;
    fetch_addr = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    for (int i = 0; i < `BOOT_IMAGE_WORDS; i++) begin
      expected_mem[i] = image_word(i);
    end
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // fetches while the image is still loading, the instruction bus stays at zero.
    for (int i = 0; i < EARLY_FETCHES; i++) begin
      fetch_en   = 1'b1;
      fetch_addr = boot_rom_pkg::ram_addr_t'(take_bits(6));
      next_cycle();
    end
    fetch_en = 1'b0;

    // a read issued during loading has to wait for ready.
    addr = boot_rom_pkg::ram_addr_t'(take_bits(6));
    apb_transfer(1'b0, addr, '0, LOAD_TIMEOUT, got);
    assert (ready) else fail_run("APB read completed before ready was raised");
    assert (got == expected_mem[addr]) else mismatch("prdata", got, expected_mem[addr]);

    for (int i = 0; i < `BOOT_IMAGE_WORDS; i++) begin
      fetch_and_check(boot_rom_pkg::ram_addr_t'(i));
    end
    repeat (32) fetch_and_check(boot_rom_pkg::ram_addr_t'(take_bits(6)));

    // patch words over APB and read them back on both ports.
    repeat (4) begin
      addr = boot_rom_pkg::ram_addr_t'(take_bits(6));
      data = take_bits(16);
      apb_transfer(1'b1, addr, data, APB_TIMEOUT, got);
      expected_mem[addr] = data;
      fetch_and_check(addr);
      apb_transfer(1'b0, addr, '0, APB_TIMEOUT, got);
      assert (got == data) else mismatch("prdata", got, data);
    end

    // a steady fetch stream holds off the APB read.
    addr       = boot_rom_pkg::ram_addr_t'(take_bits(6));
    fetch_en   = 1'b1;
    fetch_addr = boot_rom_pkg::ram_addr_t'(take_bits(6));
    psel       = 1'b1;
    pwrite     = 1'b0;
    paddr      = addr;
    for (int i = 0; i < HOLD_CYCLES; i++) begin
      next_cycle();
      penable = 1'b1;
      assert (!pready) else fail_run("APB read completed while fetch_en was held high");
      assert (instruction == expected_mem[fetch_addr]) else mismatch("instruction",
          instruction, expected_mem[fetch_addr]);
      fetch_addr = boot_rom_pkg::ram_addr_t'(take_bits(6));
    end
    fetch_en = 1'b0;
    wait_for_pready(APB_TIMEOUT);
    assert (prdata == expected_mem[addr]) else mismatch("prdata", prdata, expected_mem[addr]);
    psel    = 1'b0;
    penable = 1'b0;

    repeat (3) next_cycle();
    if (u_boot_rom_top.u_boot_rom_sva.failures == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      fail_run("assertion failures were reported during the run");
    end
  end

endmodule

/* filelist.f */
+incdir+common
common/boot_rom_pkg.sv
flash/spi_flash_reader.sv
flash/image_loader.sv
verilog/shadow_ram.sv
verilog/ram_arbiter.sv
verilog/apb_ram_port.sv
verilog/boot_rom_top.sv
testbench/spi_flash_model.sv
testbench/boot_rom_sva.sv
testbench/boot_rom_tb.sv
